//--- Bender.yml
package:
  name: vend_ctrl

dependencies: {}

sources:
  - files:
      - verilog/vend_pkg.sv
      - verilog/coin_bank_if.sv
      - verilog/coin_sync.sv
      - verilog/coin_inventory.sv
      - verilog/change_payer.sv
      - verilog/vend_ctrl.sv
      - verilog/vend_top.sv
  - target: test
    files:
      - tests/vend_top_tb.sv

//--- sources.f
verilog/vend_pkg.sv
verilog/coin_bank_if.sv
verilog/coin_sync.sv
verilog/coin_inventory.sv
verilog/change_payer.sv
verilog/vend_ctrl.sv
verilog/vend_top.sv
tests/vend_top_tb.sv

//--- tests/vend_top_tb.sv
/*
 * self-checking testbench for vend_top: directed coin, vend and refund cases,
 * then a seeded random run checked against a model of credit, stock and payout
 */
`timescale 1ns/1ps
`default_nettype none

module vend_top_tb;

    import vend_pkg::*;

    localparam int dispense_code   = 0;
    localparam int settle_limit    = 40;
    localparam int random_events   = 200;
    localparam int drain_pairs     = 7;
    localparam int total_events    = 10 + 2 * drain_pairs + random_events;
    localparam int watchdog_cycles = total_events * 60 + 500;

    logic    clk;
    logic    rst;
    logic    coin_5;
    logic    coin_10;
    logic    coin_25;
    logic    return_req;
    logic    dispense_item;
    logic    return_5;
    logic    return_10;
    logic    return_25;
    credit_t amount;
    logic    exact_change_only;

    // expected dispense and payout pulses, oldest first
    int     exp_q[$];

    // model state, stock index 0 is the 5 cent tube, 1 the 10, 2 the 25
    int     m_credit;
    stock_t m_stock [3];
    bit     m_exact;
    bit     last_disp;
    int     last_pays [8];
    int     last_npay;

    int errors;
    int test_num;
    int test_start;
    int pass_count;
    int fail_count;

    vend_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .coin_5            (coin_5),
        .coin_10           (coin_10),
        .coin_25           (coin_25),
        .return_req        (return_req),
        .dispense_item     (dispense_item),
        .return_5          (return_5),
        .return_10         (return_10),
        .return_25         (return_25),
        .amount            (amount),
        .exact_change_only (exact_change_only)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected outcome of one coin (5, 10, 25) or refund (0) on the model
    function automatic void ref_step(
        input  int     ev,
        inout  int     credit,
        inout  stock_t s5,
        inout  stock_t s10,
        inout  stock_t s25,
        output bit     disp,
        output int     pays [8],
        output int     npay,
        output bit     exact
    );
        int r;
        r    = 0;
        disp = 1'b0;
        npay = 0;
        for (int k = 0; k < 8; k++) begin
            pays[k] = 0;
        end
        if (ev == 0) begin
            r      = credit;
            credit = 0;
        end else begin
            // a full tube takes the coin without counting it
            if (ev == 5 && s5 != tube_max) s5 = s5 + 1'b1;
            if (ev == 10 && s10 != tube_max) s10 = s10 + 1'b1;
            if (ev == 25 && s25 != tube_max) s25 = s25 + 1'b1;
            credit = credit + ev;
            if (credit >= int'(price)) begin
                disp   = 1'b1;
                r      = credit - int'(price);
                credit = 0;
            end
        end
        // largest coin in stock first, a remainder nothing fits is dropped
        for (int k = 0; k < 8; k++) begin
            if (r >= 25 && s25 != 0) begin
                pays[npay] = 25;
                npay++;
                s25 = s25 - 1'b1;
                r   = r - 25;
            end else if (r >= 10 && s10 != 0) begin
                pays[npay] = 10;
                npay++;
                s10 = s10 - 1'b1;
                r   = r - 10;
            end else if (r >= 5 && s5 != 0) begin
                pays[npay] = 5;
                npay++;
                s5 = s5 - 1'b1;
                r  = r - 5;
            end
        end
        exact = (s5 == 0) && (s10 == 0);
    endfunction

    function automatic int tube_index(input int value);
        return (value == 5) ? 0 : (value == 10) ? 1 : 2;
    endfunction

    // a second coin is safe during payout if its tube is stocked and not paid from
    function automatic int pick_safe_coin(input int busy_coin);
        int start;
        int c;
        bit listed;
        start = $urandom_range(2, 0);
        for (int k = 0; k < 3; k++) begin
            c      = (((start + k) % 3) == 0) ? 5 : (((start + k) % 3) == 1) ? 10 : 25;
            listed = 1'b0;
            for (int j = 0; j < last_npay; j++) begin
                if (last_pays[j] == c) listed = 1'b1;
            end
            if (c != busy_coin && !listed && m_stock[tube_index(c)] != 0) begin
                return c;
            end
        end
        return 0;
    endfunction

    task automatic model_event(input int ev);
        ref_step(ev, m_credit, m_stock[0], m_stock[1], m_stock[2],
                 last_disp, last_pays, last_npay, m_exact);
        if (last_disp) exp_q.push_back(dispense_code);
        for (int k = 0; k < last_npay; k++) begin
            exp_q.push_back(last_pays[k]);
        end
    endtask

    task automatic set_coin(input int value, input logic level);
        case (value)
            5:       coin_5 <= level;
            10:      coin_10 <= level;
            default: coin_25 <= level;
        endcase
    endtask

    task automatic drive_coin(input int value, input int hold);
        @(posedge clk);
        set_coin(value, 1'b1);
        repeat (hold) @(posedge clk);
        set_coin(value, 1'b0);
        repeat (3) @(posedge clk);
    endtask

    task automatic drive_event(input int ev, input int hold);
        if (ev == 0) begin
            @(posedge clk);
            return_req <= 1'b1;
            @(posedge clk);
            return_req <= 1'b0;
        end else begin
            drive_coin(ev, hold);
        end
    endtask

    // wait for all pulses and a resting FSM, then compare credit and flag
    task automatic settle_and_check();
        int  cycles;
        bit  done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < settle_limit) begin
            @(negedge clk);
            cycles++;
            done = (exp_q.size() == 0) &&
                   (dut_i.vend_ctrl_i.state == idle || dut_i.vend_ctrl_i.state == collect);
        end
        assert (done) else begin
            $display("no dispense or payout within %0d cycles, %0d pulses missing, state %s",
                     settle_limit, exp_q.size(), dut_i.vend_ctrl_i.state.name());
            errors++;
            exp_q.delete();
        end
        assert (amount == credit_t'(m_credit)) else begin
            $display("Mismatch amount: expected 0x%02h, got 0x%02h", m_credit[7:0], amount);
            errors++;
        end
        assert (exact_change_only == m_exact) else begin
            $display("Mismatch exact_change_only: expected 0x%0h, got 0x%0h",
                     m_exact, exact_change_only);
            errors++;
        end
    endtask

    task automatic run_event(input int ev, input int hold);
        model_event(ev);
        drive_event(ev, hold);
        settle_and_check();
    endtask

    task automatic check_pulse(input int got, input string name);
        int want;
        assert (exp_q.size() != 0) else begin
            $display("unexpected pulse on %s while nothing was pending", name);
            errors++;
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            assert (got == want) else begin
                $display("Mismatch %s: expected 0x%02h, got 0x%02h", name, want, got);
                errors++;
            end
        end
    endtask

    task automatic begin_test();
        test_num++;
        test_start = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start) begin
            pass_count++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed with %0d errors", test_num, name, errors - test_start);
        end
    endtask

    // pulses are sampled in the middle of the cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (dispense_item) check_pulse(dispense_code, "dispense_item");
            if (return_5) check_pulse(5, "return_5");
            if (return_10) check_pulse(10, "return_10");
            if (return_25) check_pulse(25, "return_25");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int i;
        int ev;
        int pick;
        int hold;
        int hold2;
        int v2;
        void'($urandom(91));
        rst        = 1'b1;
        coin_5     = 1'b0;
        coin_10    = 1'b0;
        coin_25    = 1'b0;
        return_req = 1'b0;
        errors     = 0;
        test_num   = 0;
        pass_count = 0;
        fail_count = 0;
        m_credit   = 0;
        m_exact    = 1'b0;
        for (int k = 0; k < 3; k++) begin
            m_stock[k] = init_stock;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        run_event(10, 15);
        end_test("long coin level");

        begin_test();
        run_event(10, 4);
        run_event(10, 3);
        run_event(5, 5);
        run_event(25, 6);
        end_test("exact price");

        begin_test();
        run_event(25, 3);
        run_event(25, 4);
        end_test("overpayment change");

        begin_test();
        run_event(5, 3);
        run_event(10, 3);
        run_event(0, 0);
        end_test("refund");

        // each 20 cent overpayment takes 10s, then 5s once the 10 tube is empty
        begin_test();
        for (int k = 0; k < drain_pairs; k++) begin
            run_event(25, 3);
            run_event(25, 3);
        end
        end_test("small coin tubes drained");

        begin_test();
        i = 0;
        while (i < random_events) begin
            pick = $urandom_range(9, 0);
            ev   = (pick < 2) ? 0 : (pick < 5) ? 5 : (pick < 8) ? 10 : 25;
            hold = $urandom_range(6, 3);
            model_event(ev);
            v2 = 0;
            if (ev != 0 && last_npay > 0 && $urandom_range(1, 0) == 1) begin
                v2 = pick_safe_coin(ev);
            end
            if (v2 != 0) begin
                // next coin lands while the change is still being paid
                hold2 = $urandom_range(6, 3);
                model_event(v2);
                fork
                    drive_coin(ev, hold);
                    begin
                        repeat (3) @(posedge clk);
                        drive_coin(v2, hold2);
                    end
                join
                i = i + 2;
            end else begin
                drive_event(ev, hold);
                i = i + 1;
            end
            settle_and_check();
        end
        end_test("random coins and refunds");

        $display("tests passed %0d failed %0d, errors %0d", pass_count, fail_count, errors);
        if (fail_count == 0 && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/change_payer.sv
/*
 * pays out a change amount one coin per cycle, largest coin in stock first;
 * load it with change_load, it answers with change_done when finished
 */
`timescale 1ns/1ps
`default_nettype none

module change_payer (
    input  logic              clk,
    input  logic              rst,
    input  logic              change_load,
    input  vend_pkg::credit_t change_value,
    coin_bank_if.payer        payer,
    output logic              change_done
);

    import vend_pkg::*;

    credit_t remain;
    credit_t pay_value;
    logic    busy;
    logic    pay_5;
    logic    pay_10;
    logic    pay_25;

    // greedy pick against the current stock flags
    always_comb begin
        pay_5       = 1'b0;
        pay_10      = 1'b0;
        pay_25      = 1'b0;
        pay_value   = '0;
        change_done = 1'b0;
        if (busy) begin
            if (remain >= coin25_value && payer.have_25) begin
                pay_25    = 1'b1;
                pay_value = coin25_value;
            end else if (remain >= coin10_value && payer.have_10) begin
                pay_10    = 1'b1;
                pay_value = coin10_value;
            end else if (remain >= coin5_value && payer.have_5) begin
                pay_5     = 1'b1;
                pay_value = coin5_value;
            end else begin
                // nothing left or nothing fits, the rest is dropped
                change_done = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (change_load) begin
            busy <= 1'b1;
        end else if (change_done) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (change_load) begin
            remain <= change_value;
        end else if (busy) begin
            remain <= remain - pay_value;
        end
    end

    assign payer.pay_5  = pay_5;
    assign payer.pay_10 = pay_10;
    assign payer.pay_25 = pay_25;

    a_pay_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({pay_25, pay_10, pay_5})
    ) else $error("more than one coin paid in a cycle");

    // the controller only hands over new change once the last payout ended
    a_load_when_free: assert property (
        @(posedge clk) disable iff (rst)
        change_load |-> !busy
    ) else $error("change loaded while a payout is running");

endmodule

`default_nettype wire

//--- verilog/coin_bank_if.sv
/*
 * link between the change payer and the coin tubes: one pay strobe
 * and one stock-available flag per coin size
 */
`timescale 1ns/1ps
`default_nettype none

interface coin_bank_if;

    // one coin out of the matching tube, at most one line per cycle
    logic pay_5;
    logic pay_10;
    logic pay_25;

    // tube holds at least one coin
    logic have_5;
    logic have_10;
    logic have_25;

    modport payer (
        output pay_5,
        output pay_10,
        output pay_25,
        input  have_5,
        input  have_10,
        input  have_25
    );

    modport bank (
        input  pay_5,
        input  pay_10,
        input  pay_25,
        output have_5,
        output have_10,
        output have_25
    );

endinterface

`default_nettype wire

//--- verilog/coin_inventory.sv
/*
 * stock counters for the 5, 10 and 25 cent tubes; coins taken in raise a
 * count, coins paid out lower it; drives the stock flags and exact change
 */
`timescale 1ns/1ps
`default_nettype none

module coin_inventory (
    input  logic       clk,
    input  logic       rst,
    input  logic       coin_5_pulse,
    input  logic       coin_10_pulse,
    input  logic       coin_25_pulse,
    coin_bank_if.bank  bank,
    output logic       exact_change_only
);

    import vend_pkg::*;

    // index 0 is the 5 cent tube, 1 the 10, 2 the 25
    logic [2:0] intake;
    logic [2:0] payout;
    logic [2:0] have;
    stock_t     count [3];

    assign intake = {coin_25_pulse, coin_10_pulse, coin_5_pulse};
    assign payout = {bank.pay_25, bank.pay_10, bank.pay_5};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                count[i] <= init_stock;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                // a coin in and a coin out of the same tube cancel
                if (intake[i] && !payout[i]) begin
                    if (count[i] != tube_max) begin
                        count[i] <= count[i] + 1'b1;
                    end
                end else if (payout[i] && !intake[i]) begin
                    if (count[i] != '0) begin
                        count[i] <= count[i] - 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            have[i] = (count[i] != '0);
        end
    end

    assign bank.have_5  = have[0];
    assign bank.have_10 = have[1];
    assign bank.have_25 = have[2];

    // no small coins left, so most overpayments cannot be returned
    assign exact_change_only = !have[0] && !have[1];

    // the payer must never draw on a tube that is empty
    a_pay_in_stock: assert property (
        @(posedge clk) disable iff (rst)
        (payout & ~have) == 3'b000
    ) else $error("coin paid from an empty tube");

endmodule

`default_nettype wire

//--- verilog/coin_sync.sv
/*
 * brings the three asynchronous coin levels into the clock domain and
 * turns each inserted coin into a single-cycle pulse
 */
`timescale 1ns/1ps
`default_nettype none

module coin_sync (
    input  logic clk,
    input  logic rst,
    input  logic coin_5,
    input  logic coin_10,
    input  logic coin_25,
    output logic coin_5_pulse,
    output logic coin_10_pulse,
    output logic coin_25_pulse
);

    // bit 0 is the 5 cent coin, bit 1 the 10, bit 2 the 25
    logic [2:0] coin_in;
    logic [2:0] sync1;
    logic [2:0] sync2;
    logic [2:0] prev;
    logic [2:0] pulse;

    assign coin_in = {coin_25, coin_10, coin_5};

    // two flops against metastability, a third one remembers the last level
    always_ff @(posedge clk) begin
        if (rst) begin
            sync1 <= '0;
            sync2 <= '0;
            prev  <= '0;
        end else begin
            sync1 <= coin_in;
            sync2 <= sync1;
            prev  <= sync2;
        end
    end

    // rising edge of the synchronized level
    assign pulse = sync2 & ~prev;

    assign coin_5_pulse  = pulse[0];
    assign coin_10_pulse = pulse[1];
    assign coin_25_pulse = pulse[2];

    // a long coin level must still credit only once
    a_pulse_single: assert property (
        @(posedge clk) disable iff (rst)
        (pulse & $past(pulse)) == 3'b000
    ) else $error("coin pulse lasted two cycles");

endmodule

`default_nettype wire

//--- verilog/vend_ctrl.sv
/*
 * credit register and vending FSM: adds coin pulses to the credit, vends
 * at the price, and hands overpayment or a refund to the change payer
 */
`timescale 1ns/1ps
`default_nettype none

module vend_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              coin_5_pulse,
    input  logic              coin_10_pulse,
    input  logic              coin_25_pulse,
    input  logic              return_req,
    input  logic              change_done,
    output vend_pkg::credit_t amount,
    output logic              dispense_item,
    output logic              change_load,
    output vend_pkg::credit_t change_value
);

    import vend_pkg::*;

    vend_state_t state;
    vend_state_t state_next;
    credit_t     add;
    credit_t     new_credit;
    credit_t     amount_next;
    credit_t     excess;
    credit_t     excess_next;
    logic        settle;

    always_comb begin
        // coins are credited in every state, even two in the same cycle
        add = '0;
        if (coin_5_pulse) begin
            add = add + coin5_value;
        end
        if (coin_10_pulse) begin
            add = add + coin10_value;
        end
        if (coin_25_pulse) begin
            add = add + coin25_value;
        end
        new_credit = amount + add;

        state_next  = state;
        amount_next = new_credit;
        excess_next = excess;
        change_load = 1'b0;
        settle      = 1'b0;

        case (state)
            idle, collect: begin
                if (state == collect && return_req && new_credit < price) begin
                    // refund; a coin landing right now stays as credit
                    change_load = 1'b1;
                    amount_next = add;
                    state_next  = pay_change;
                end else begin
                    settle = 1'b1;
                end
            end
            vend: begin
                if (excess != '0) begin
                    change_load = 1'b1;
                    state_next  = pay_change;
                end else begin
                    settle = 1'b1;
                end
            end
            pay_change: begin
                if (change_done) begin
                    settle = 1'b1;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase

        // pick the resting state from the credit, or start another vend
        if (settle) begin
            if (new_credit >= price) begin
                state_next  = vend;
                excess_next = new_credit - price;
                amount_next = '0;
            end else if (new_credit != '0) begin
                state_next = collect;
            end else begin
                state_next = idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= idle;
            amount <= '0;
        end else begin
            state  <= state_next;
            amount <= amount_next;
        end
    end

    always_ff @(posedge clk) begin
        excess <= excess_next;
    end

    assign dispense_item = (state == vend);

    // refund takes the whole credit, a vend only its overpayment
    assign change_value = (state == collect) ? amount : excess;

    // a vend follows a cycle whose credit reached the price, and spends it
    a_dispense_paid: assert property (
        @(posedge clk) disable iff (rst)
        dispense_item |-> ($past(new_credit) >= price) && (amount == '0)
    ) else $error("dispense without the price in credit or with credit left");

endmodule

`default_nettype wire

//--- verilog/vend_pkg.sv
/*
 * shared money and stock types, coin values, price and tube limits
 * for the vending controller; imported by the RTL and the testbench
 */
`default_nettype none

package vend_pkg;

    // money in cents, wide enough for credit plus a burst of coins
    typedef logic [7:0] credit_t;

    // coins held in one tube
    typedef logic [3:0] stock_t;

    // item price in cents
    localparam credit_t price = 8'd30;

    // accepted coin values
    localparam credit_t coin5_value  = 8'd5;
    localparam credit_t coin10_value = 8'd10;
    localparam credit_t coin25_value = 8'd25;

    // tube fill after reset
    localparam stock_t init_stock = 4'd8;

    // a full tube; further coins drop into the cash box uncounted
    localparam stock_t tube_max = 4'd15;

    // controller states
    //   idle        no credit
    //   collect     some credit, below price
    //   vend        item is dispensed this cycle
    //   pay_change  waiting for the change payer to finish
    typedef enum logic [1:0] {
        idle,
        collect,
        vend,
        pay_change
    } vend_state_t;

endpackage

`default_nettype wire

//--- verilog/vend_top.sv
/*
 * vending controller top level: coin synchronizer, controller,
 * change payer and tube inventory behind plain ports
 */
`timescale 1ns/1ps
`default_nettype none

module vend_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              coin_5,
    input  logic              coin_10,
    input  logic              coin_25,
    input  logic              return_req,
    output logic              dispense_item,
    output logic              return_5,
    output logic              return_10,
    output logic              return_25,
    output vend_pkg::credit_t amount,
    output logic              exact_change_only
);

    import vend_pkg::*;

    logic    coin_5_pulse;
    logic    coin_10_pulse;
    logic    coin_25_pulse;
    logic    change_load;
    logic    change_done;
    credit_t change_value;

    coin_bank_if bank_if ();

    coin_sync coin_sync_i (
        .clk           (clk),
        .rst           (rst),
        .coin_5        (coin_5),
        .coin_10       (coin_10),
        .coin_25       (coin_25),
        .coin_5_pulse  (coin_5_pulse),
        .coin_10_pulse (coin_10_pulse),
        .coin_25_pulse (coin_25_pulse)
    );

    vend_ctrl vend_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .coin_5_pulse  (coin_5_pulse),
        .coin_10_pulse (coin_10_pulse),
        .coin_25_pulse (coin_25_pulse),
        .return_req    (return_req),
        .change_done   (change_done),
        .amount        (amount),
        .dispense_item (dispense_item),
        .change_load   (change_load),
        .change_value  (change_value)
    );

    change_payer change_payer_i (
        .clk          (clk),
        .rst          (rst),
        .change_load  (change_load),
        .change_value (change_value),
        .payer        (bank_if.payer),
        .change_done  (change_done)
    );

    coin_inventory coin_inventory_i (
        .clk               (clk),
        .rst               (rst),
        .coin_5_pulse      (coin_5_pulse),
        .coin_10_pulse     (coin_10_pulse),
        .coin_25_pulse     (coin_25_pulse),
        .bank              (bank_if.bank),
        .exact_change_only (exact_change_only)
    );

    // the pay strobes are the coins dropped to the customer
    assign return_5  = bank_if.pay_5;
    assign return_10 = bank_if.pay_10;
    assign return_25 = bank_if.pay_25;

endmodule

`default_nettype wire
